// File: logic/fmul_pkg.sv
//////////////////////////////////////////////////
// Shared widths and state types for the FP multiply unit
// Widths here are defaults only, the top level passes
// the real EXP_W and MAN_W down to every block
// Format is IEEE single precision, sign on top
//////////////////////////////////////////////////

package fmul_pkg;

  //////////////////////////////////////////////////
  // Default field widths
  //////////////////////////////////////////////////

  // Biased exponent field
  parameter int FMUL_EXP_W = 8;

  // Stored mantissa, hidden bit not included
  parameter int FMUL_MAN_W = 23;

  //////////////////////////////////////////////////
  // State types
  //////////////////////////////////////////////////

  // Availability seen by the issue logic
  typedef enum logic
  {
    FREE = 1'b0,
    BUSY = 1'b1
  } fu_state_e;

  // Phases of one multiply pass
  typedef enum logic [1:0]
  {
    IDLE      = 2'd0,
    PREPARE   = 2'd1,
    MULTIPLY  = 2'd2,
    NORMALIZE = 2'd3
  } fmul_state_e;

endpackage : fmul_pkg

// File: logic/fmul_ctrl_fsm.sv
//////////////////////////////////////////////////
// Pass sequencer, IDLE PREPARE MULTIPLY NORMALIZE
// No start strobe, a new pass begins after each IDLE
// Holds IDLE one extra enabled cycle after reset
// All strobes are single cycle and gated by clk_en_i
//////////////////////////////////////////////////

module fmul_ctrl_fsm
  import fmul_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      clk_en_i,
  input  logic      last_step_i,
  output logic      capture_o,
  output logic      prepare_o,
  output logic      step_o,
  output logic      normalize_o,
  output logic      valid_o,
  output fu_state_e fu_state_o
);

  fmul_state_e state_q;
  fmul_state_e state_d;

  // Delayed copy of reset
  logic        rst_dly_q;

  // Goes high one enabled cycle after reset release
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rst_dly_q <= 1'b0;
    else if (clk_en_i)
      rst_dly_q <= 1'b1;
  end

  //////////////////////////////////////////////////
  // State register and next state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_q <= IDLE;
    else if (clk_en_i)
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      // Second IDLE cycle after reset starts the first pass
      IDLE:      state_d = rst_dly_q ? PREPARE : IDLE;
      PREPARE:   state_d = MULTIPLY;
      // Counter flags the final Booth iteration
      MULTIPLY:  state_d = last_step_i ? NORMALIZE : MULTIPLY;
      NORMALIZE: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Phase strobes
  //////////////////////////////////////////////////

  assign capture_o   = clk_en_i & (state_q == IDLE);
  assign prepare_o   = clk_en_i & (state_q == PREPARE);
  assign step_o      = clk_en_i & (state_q == MULTIPLY);
  assign normalize_o = clk_en_i & (state_q == NORMALIZE);

  // Result register was loaded in the NORMALIZE just before
  assign valid_o     = clk_en_i & (state_q == IDLE);
  assign fu_state_o  = (state_q == IDLE) ? FREE : BUSY;

endmodule : fmul_ctrl_fsm

// File: logic/booth_step_counter.sv
//////////////////////////////////////////////////
// Radix-4 iteration counter
// Step count is (MAN_W+2)/2, 12 for a 24-bit significand
// last_step_o is high during the final step cycle
//////////////////////////////////////////////////

module booth_step_counter
  import fmul_pkg::*;
#(
  parameter int MAN_W = FMUL_MAN_W
)
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic clk_en_i,
  input  logic load_i,
  input  logic step_i,
  output logic last_step_o
);

  // Two multiplier bits retired per step
  localparam int STEPS = (MAN_W + 2) / 2;
  localparam int CNT_W = $clog2(STEPS + 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      count_q <= '0;
    else if (clk_en_i)
    begin
      if (load_i)
        count_q <= CNT_W'(STEPS);
      else if (step_i && (count_q != '0))
        count_q <= count_q - 1'b1;
    end
  end

  // One step left means this is the last one
  assign last_step_o = (count_q == CNT_W'(1));

endmodule : booth_step_counter

// File: logic/booth_r4_mantissa_mul.sv
//////////////////////////////////////////////////
// Iterative radix-4 Booth significand multiplier
// Unsigned operands of MAN_W+1 bits, MAN_W+1 must be even
// One pair of multiplier bits per step_i
// product_o valid from the cycle after the last step
//////////////////////////////////////////////////

module booth_r4_mantissa_mul
  import fmul_pkg::*;
#(
  parameter int MAN_W = FMUL_MAN_W
)
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   clk_en_i,
  input  logic                   load_i,
  input  logic                   step_i,
  input  logic [MAN_W:0]         multiplicand_i,
  input  logic [MAN_W:0]         multiplier_i,
  output logic [2*(MAN_W+1)-1:0] product_o
);

  localparam int SIG_W  = MAN_W + 1;
  localparam int PROD_W = 2 * SIG_W;
  // Signed accumulator holds up to +-2M plus headroom
  localparam int ACC_W  = SIG_W + 2;
  // Multiplier plus the appended recode bit
  localparam int LOW_W  = SIG_W + 1;
  localparam int REG_W  = ACC_W + LOW_W;

  logic [SIG_W-1:0]        mcand_q;
  logic [REG_W-1:0]        prod_q;
  logic signed [ACC_W-1:0] m_ext;
  logic signed [ACC_W-1:0] pp;
  logic signed [ACC_W-1:0] acc_sum;
  logic signed [REG_W-1:0] prod_shift;
  logic [SIG_W-1:0]        top_fix;

  //////////////////////////////////////////////////
  // Booth recode of the low three bits
  //////////////////////////////////////////////////

  assign m_ext = signed'({2'b00, mcand_q});

  always_comb
  begin
    unique case (prod_q[2:0])
      3'b001, 3'b010: pp = m_ext;
      3'b011:         pp = m_ext <<< 1;
      3'b100:         pp = -(m_ext <<< 1);
      3'b101, 3'b110: pp = -m_ext;
      default:        pp = '0;
    endcase
  end

  // Add into the upper half, then arithmetic shift by two
  assign acc_sum    = signed'(prod_q[REG_W-1 -: ACC_W]) + pp;
  assign prod_shift = signed'({acc_sum, prod_q[LOW_W-1:0]}) >>> 2;

  //////////////////////////////////////////////////
  // Product register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (clk_en_i && load_i)
      mcand_q <= multiplicand_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      prod_q <= '0;
    else if (clk_en_i)
    begin
      if (load_i)
        prod_q <= {{ACC_W{1'b0}}, multiplier_i, 1'b0};
      else if (step_i)
        prod_q <= prod_shift;
    end
  end

  //////////////////////////////////////////////////
  // Unsigned result
  //////////////////////////////////////////////////

  // Recode bit now holds the multiplier MSB
  // Booth treated it as a sign, so add M back at the top
  assign top_fix = prod_q[0] ? mcand_q : '0;

  assign product_o = {prod_q[PROD_W:SIG_W+1] + top_fix, prod_q[SIG_W:1]};

endmodule : booth_r4_mantissa_mul

// File: logic/fmul_exp_sign.sv
//////////////////////////////////////////////////
// Operand capture, exponent sum and result sign
// Exponent zero counts as zero, denormals are flushed
// exp_sum_o is signed so underflow shows as <= 0
// No overflow or NaN detection
//////////////////////////////////////////////////

module fmul_exp_sign
  import fmul_pkg::*;
#(
  parameter int EXP_W = FMUL_EXP_W,
  parameter int MAN_W = FMUL_MAN_W
)
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clk_en_i,
  input  logic                      capture_i,
  input  logic                      prepare_i,
  input  logic [EXP_W+MAN_W:0]      op_a_i,
  input  logic [EXP_W+MAN_W:0]      op_b_i,
  output logic [MAN_W:0]            sig_a_o,
  output logic [MAN_W:0]            sig_b_o,
  output logic signed [EXP_W+1:0]   exp_sum_o,
  output logic                      sign_o,
  output logic                      zero_o
);

  // All ones, one bit narrower than the exponent
  localparam int BIAS = (1 << (EXP_W - 1)) - 1;

  logic [EXP_W+MAN_W:0]    op_a_q;
  logic [EXP_W+MAN_W:0]    op_b_q;
  logic [EXP_W-1:0]        exp_a;
  logic [EXP_W-1:0]        exp_b;
  logic signed [EXP_W+1:0] exp_sum_d;

  // Operand hold, loaded every enabled IDLE cycle
  always_ff @(posedge clk_i)
  begin
    if (clk_en_i && capture_i)
    begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  assign exp_a = op_a_q[EXP_W+MAN_W-1 -: EXP_W];
  assign exp_b = op_b_q[EXP_W+MAN_W-1 -: EXP_W];

  // Hidden bit only for a nonzero exponent
  assign sig_a_o = {|exp_a, op_a_q[MAN_W-1:0]};
  assign sig_b_o = {|exp_b, op_b_q[MAN_W-1:0]};

  // Two biased exponents, so one bias comes off
  assign exp_sum_d = signed'({2'b00, exp_a}) + signed'({2'b00, exp_b})
                   - signed'((EXP_W + 2)'(BIAS));

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      exp_sum_o <= '0;
      sign_o    <= 1'b0;
      zero_o    <= 1'b1;
    end
    else if (clk_en_i && prepare_i)
    begin
      exp_sum_o <= exp_sum_d;
      sign_o    <= op_a_q[EXP_W+MAN_W] ^ op_b_q[EXP_W+MAN_W];
      zero_o    <= ~(|exp_a) | ~(|exp_b);
    end
  end

endmodule : fmul_exp_sign

// File: logic/fmul_normalize.sv
//////////////////////////////////////////////////
// One-position normalize and result register
// Mantissa is truncated, no rounding
// Zero operand or exponent <= 0 gives a signed zero
// Exponent overflow wraps silently
//////////////////////////////////////////////////

module fmul_normalize
  import fmul_pkg::*;
#(
  parameter int EXP_W = FMUL_EXP_W,
  parameter int MAN_W = FMUL_MAN_W
)
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clk_en_i,
  input  logic                       load_i,
  input  logic [2*(MAN_W+1)-1:0]     product_i,
  input  logic signed [EXP_W+1:0]    exp_sum_i,
  input  logic                       sign_i,
  input  logic                       zero_i,
  output logic [EXP_W+MAN_W:0]       result_o
);

  localparam int PROD_W = 2 * (MAN_W + 1);

  logic                    top_bit;
  logic [MAN_W-1:0]        man_norm;
  logic signed [EXP_W+1:0] exp_adj;
  logic                    flush;

  // Product of two 1.x values lies in [1,4)
  assign top_bit = product_i[PROD_W-1];

  // Take the bits below the leading one
  assign man_norm = top_bit ? product_i[PROD_W-2 -: MAN_W]
                            : product_i[PROD_W-3 -: MAN_W];

  assign exp_adj = exp_sum_i + signed'({{(EXP_W+1){1'b0}}, top_bit});

  // Underflow check on the adjusted exponent
  assign flush = zero_i | (exp_adj <= 0);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      result_o <= '0;
    else if (clk_en_i && load_i)
    begin
      if (flush)
        result_o <= {sign_i, {(EXP_W+MAN_W){1'b0}}};
      else
        result_o <= {sign_i, exp_adj[EXP_W-1:0], man_norm};
    end
  end

endmodule : fmul_normalize

// File: logic/fp_mul_unit.sv
//////////////////////////////////////////////////
// Single precision multiply, 15 enabled cycles a pass
// Operands sampled every enabled IDLE cycle
// valid_o marks the IDLE after each NORMALIZE
// Truncating, no infinities, NaNs or exceptions
//////////////////////////////////////////////////

module fp_mul_unit
  import fmul_pkg::*;
#(
  parameter int EXP_W = FMUL_EXP_W,
  parameter int MAN_W = FMUL_MAN_W
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 clk_en_i,
  input  logic [EXP_W+MAN_W:0] multiplier_i,
  input  logic [EXP_W+MAN_W:0] multiplicand_i,
  output logic [EXP_W+MAN_W:0] result_o,
  output logic                 valid_o,
  output fu_state_e            fu_state_o
);

  // Phase strobes
  logic capture;
  logic prepare;
  logic step;
  logic normalize;
  logic last_step;

  // Datapath between the stages
  logic [MAN_W:0]            sig_a;
  logic [MAN_W:0]            sig_b;
  logic [2*(MAN_W+1)-1:0]    product;
  logic signed [EXP_W+1:0]   exp_sum;
  logic                      sign;
  logic                      zero;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  fmul_ctrl_fsm u_ctrl (
    .clk_i, .rst_n_i, .clk_en_i,
    .last_step_i (last_step), .capture_o (capture), .prepare_o (prepare),
    .step_o (step), .normalize_o (normalize), .valid_o, .fu_state_o
  );

  booth_step_counter #(.MAN_W(MAN_W)) u_step_cnt (
    .clk_i, .rst_n_i, .clk_en_i,
    .load_i (prepare), .step_i (step), .last_step_o (last_step)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  fmul_exp_sign #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_exp_sign (
    .clk_i, .rst_n_i, .clk_en_i,
    .capture_i (capture), .prepare_i (prepare),
    .op_a_i (multiplier_i), .op_b_i (multiplicand_i),
    .sig_a_o (sig_a), .sig_b_o (sig_b),
    .exp_sum_o (exp_sum), .sign_o (sign), .zero_o (zero)
  );

  // Significands load while the exponent sum registers
  booth_r4_mantissa_mul #(.MAN_W(MAN_W)) u_booth (
    .clk_i, .rst_n_i, .clk_en_i,
    .load_i (prepare), .step_i (step),
    .multiplicand_i (sig_b), .multiplier_i (sig_a), .product_o (product)
  );

  fmul_normalize #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_normalize (
    .clk_i, .rst_n_i, .clk_en_i,
    .load_i (normalize), .product_i (product), .exp_sum_i (exp_sum),
    .sign_i (sign), .zero_i (zero), .result_o
  );

endmodule : fp_mul_unit

// File: dv/tb_fp_mul_unit.sv
//////////////////////////////////////////////////
// Directed testbench for the FP multiply unit
// Inputs driven 2 after the rising edge, outputs sampled at 1
// Each pass is expected to take 14 BUSY cycles plus one IDLE
//////////////////////////////////////////////////

module tb_fp_mul_unit
  import fmul_pkg::*;
();

  typedef logic [FMUL_EXP_W+FMUL_MAN_W:0] fp_t;

  // Reset pass, 4 signs, 1.25, 3 zero cases, 200 random, stall, hold
  localparam int N_TESTS   = 211;
  localparam int CYC_LIMIT = N_TESTS * 16 + 100;

  logic      clk_i;
  logic      rst_n_i;
  logic      clk_en_i;
  fp_t       multiplier_i;
  fp_t       multiplicand_i;
  fp_t       result_o;
  logic      valid_o;
  fu_state_e fu_state_o;

  integer seed;
  int     err_cnt;
  int     test_cnt;
  int     bad_tests;
  int     test_start_errs;
  int     cycle_cnt;

  fp_mul_unit u_fp_mul_unit (
    .clk_i, .rst_n_i, .clk_en_i, .multiplier_i, .multiplicand_i,
    .result_o, .valid_o, .fu_state_o
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= CYC_LIMIT)
    begin
      $display("timeout, no result after %0d cycles", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and compares
  //////////////////////////////////////////////////

  // Sign XOR, exponent sum less bias, 24x24 product, truncate
  function automatic fp_t expected_product(fp_t a, fp_t b);
    logic        sign;
    logic [47:0] p;
    int          e;
    logic [22:0] man;
    sign = a[31] ^ b[31];
    if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
      return {sign, 31'd0};
    p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - 127;
    // Product in [2,4) moves the point by one
    if (p[47])
    begin
      man = p[46:24];
      e++;
    end
    else
      man = p[45:23];
    if (e <= 0)
      return {sign, 31'd0};
    return {sign, e[7:0], man};
  endfunction

  // Exponent kept in 64..190 so sums stay in range
  function automatic fp_t random_operand();
    logic [31:0] r;
    logic [7:0]  e;
    r = $random(seed);
    e = 8'd64 + 8'(r[31:24] % 127);
    return {r[23], e, r[22:0]};
  endfunction

  task automatic compare_result(string name, fp_t got, fp_t exp);
    if (got !== exp)
    begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_state(string name, fu_state_e got, fu_state_e exp);
    if (got !== exp)
    begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // One pass, started from an IDLE sample point
  //////////////////////////////////////////////////

  // At BUSY cycle mid_at, optionally swap operands and stall
  task automatic run_pass(string name, fp_t a, fp_t b, fp_t exp, int mid_at,
                          int stall_len, bit swap, fp_t new_a, fp_t new_b);
    fp_t held;
    int  busy;
    held = result_o;
    busy = 0;
    #1;
    multiplier_i   = a;
    multiplicand_i = b;
    do
    begin
      @(posedge clk_i);
      #1;
      if (fu_state_o == BUSY)
      begin
        busy++;
        // Old result stays until the next valid
        compare_result("result_o", result_o, held);
        if (valid_o)
        begin
          $display("valid_o went high while the unit was busy");
          err_cnt++;
        end
        if (busy == mid_at)
        begin
          #1;
          if (swap)
          begin
            multiplier_i   = new_a;
            multiplicand_i = new_b;
          end
          if (stall_len > 0)
          begin
            clk_en_i = 1'b0;
            repeat (stall_len)
            begin
              @(posedge clk_i);
              #1;
              if (valid_o)
              begin
                $display("valid_o went high during the clock enable stall");
                err_cnt++;
              end
              compare_result("result_o", result_o, held);
              compare_state("fu_state_o", fu_state_o, BUSY);
            end
            #1;
            clk_en_i = 1'b1;
          end
        end
      end
    end
    while (!(fu_state_o == FREE && valid_o));
    if (busy != 14)
    begin
      $display("%s took %0d busy cycles instead of 14", name, busy);
      err_cnt++;
    end
    compare_result("result_o", result_o, exp);
    test_cnt++;
    if (err_cnt != test_start_errs)
      bad_tests++;
    $display("%s: %s", name, (err_cnt == test_start_errs) ? "ok" : "failed");
    test_start_errs = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    fp_t a;
    fp_t b;
    rst_n_i        = 1'b0;
    clk_en_i       = 1'b1;
    multiplier_i   = '0;
    multiplicand_i = '0;
    seed           = 32'h2145;
    repeat (5) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
    clk_en_i = 1'b0;
    // First IDLE cycle after reset, stalled
    @(posedge clk_i);
    #1;
    compare_state("fu_state_o", fu_state_o, FREE);
    if (valid_o !== 1'b0)
    begin
      $display("valid_o high in IDLE while the clock enable was low");
      err_cnt++;
    end
    #1;
    clk_en_i = 1'b1;
    // Second IDLE cycle after reset
    @(posedge clk_i);
    #1;
    compare_state("fu_state_o", fu_state_o, FREE);
    compare_result("result_o", result_o, '0);
    if (valid_o !== 1'b1)
    begin
      $display("valid_o not high in IDLE after reset");
      err_cnt++;
    end
    run_pass("reset and 1.0 x 1.0", 32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000,
             0, 0, 1'b0, '0, '0);
    // Top product bit set, all sign pairs
    run_pass("1.5 x 1.5", 32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000, 0, 0, 1'b0, '0, '0);
    run_pass("-1.5 x 1.5", 32'hBFC0_0000, 32'h3FC0_0000, 32'hC010_0000, 0, 0, 1'b0, '0, '0);
    run_pass("1.5 x -1.5", 32'h3FC0_0000, 32'hBFC0_0000, 32'hC010_0000, 0, 0, 1'b0, '0, '0);
    run_pass("-1.5 x -1.5", 32'hBFC0_0000, 32'hBFC0_0000, 32'h4010_0000, 0, 0, 1'b0, '0, '0);
    // No shift needed
    run_pass("1.25 x 1.25", 32'h3FA0_0000, 32'h3FA0_0000, 32'h3FC8_0000, 0, 0, 1'b0, '0, '0);
    run_pass("-0 x 1.5", 32'h8000_0000, 32'h3FC0_0000, 32'h8000_0000, 0, 0, 1'b0, '0, '0);
    run_pass("-1.5 x denormal", 32'hBFC0_0000, 32'h0012_3456, 32'h8000_0000,
             0, 0, 1'b0, '0, '0);
    run_pass("exponent underflow", {1'b1, 8'd20, 23'h012345}, {1'b1, 8'd30, 23'h0},
             32'h0000_0000, 0, 0, 1'b0, '0, '0);
    for (int i = 0; i < 200; i++)
    begin
      a = random_operand();
      b = random_operand();
      run_pass($sformatf("random %0d", i), a, b, expected_product(a, b),
               0, 0, 1'b0, '0, '0);
    end
    // Stall inside MULTIPLY
    a = random_operand();
    b = random_operand();
    run_pass("clock enable stall", a, b, expected_product(a, b), 6, 5, 1'b0, '0, '0);
    // Operands change during PREPARE, after capture
    run_pass("operand hold", 32'h3FA0_0000, 32'hBFC0_0000, 32'hBFF0_0000,
             1, 0, 1'b1, 32'h4040_0000, 32'h4080_0000);
    $display("tests %0d, failed tests %0d, errors %0d", test_cnt, bad_tests, err_cnt);
    if (err_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule : tb_fp_mul_unit

// File: sim.f
logic/fmul_pkg.sv
logic/fmul_ctrl_fsm.sv
logic/booth_step_counter.sv
logic/booth_r4_mantissa_mul.sv
logic/fmul_exp_sign.sv
logic/fmul_normalize.sv
logic/fp_mul_unit.sv
dv/tb_fp_mul_unit.sv

// File: Bender.yml
package:
  name: fp_mul_unit

sources:
  - logic/fmul_pkg.sv
  - logic/fmul_ctrl_fsm.sv
  - logic/booth_step_counter.sv
  - logic/booth_r4_mantissa_mul.sv
  - logic/fmul_exp_sign.sv
  - logic/fmul_normalize.sv
  - logic/fp_mul_unit.sv
  - target: simulation
    files:
      - dv/tb_fp_mul_unit.sv
